// File: hdl/mips_pkg.sv
package mips_pkg;

	// instruction word formats
	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} r_fmt_t;

	typedef struct packed {
		logic [5:0]  opcode;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm;
	} i_fmt_t;

	typedef struct packed {
		logic [5:0]  opcode;
		logic [25:0] target;
	} j_fmt_t;

	// one 32-bit word, three views
	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
		j_fmt_t j;
	} instr_t;

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_slt,  // signed compare
		alu_sll,
		alu_srl
	} alu_op_e;

	typedef enum logic [3:0] {
		st_fetch,
		st_decode,
		st_mem_addr,
		st_mem_read,
		st_mem_wb,
		st_mem_write,
		st_exec_r,
		st_exec_i,
		st_alu_wb,
		st_branch,
		st_jump
	} state_e;

	// opcodes
	localparam logic [5:0] op_rtype = 6'h00;
	localparam logic [5:0] op_j     = 6'h02;
	localparam logic [5:0] op_jal   = 6'h03;
	localparam logic [5:0] op_beq   = 6'h04;
	localparam logic [5:0] op_bne   = 6'h05;
	localparam logic [5:0] op_addi  = 6'h08;
	localparam logic [5:0] op_andi  = 6'h0c;
	localparam logic [5:0] op_ori   = 6'h0d;
	localparam logic [5:0] op_lw    = 6'h23;
	localparam logic [5:0] op_sw    = 6'h2b;

	// r-type funct codes
	localparam logic [5:0] fn_sll = 6'h00;
	localparam logic [5:0] fn_srl = 6'h02;
	localparam logic [5:0] fn_add = 6'h20;
	localparam logic [5:0] fn_sub = 6'h22;
	localparam logic [5:0] fn_and = 6'h24;
	localparam logic [5:0] fn_or  = 6'h25;
	localparam logic [5:0] fn_slt = 6'h2a;

	// select encodings
	localparam logic [1:0] dst_rt       = 2'd0;
	localparam logic [1:0] dst_rd       = 2'd1;
	localparam logic [1:0] dst_r31      = 2'd2;  // jal link
	localparam logic [1:0] srca_pc      = 2'd0;
	localparam logic [1:0] srca_a       = 2'd1;
	localparam logic [1:0] srca_shamt   = 2'd2;
	localparam logic [1:0] srcb_b       = 2'd0;
	localparam logic [1:0] srcb_four    = 2'd1;
	localparam logic [1:0] srcb_ext     = 2'd2;
	localparam logic [1:0] srcb_ext_sh2 = 2'd3;  // branch offset
	localparam logic [1:0] pcsrc_alu    = 2'd0;
	localparam logic [1:0] pcsrc_aluout = 2'd1;
	localparam logic [1:0] pcsrc_jump   = 2'd2;

	// per-cycle control, fsm to datapath
	typedef struct packed {
		logic       pc_write;
		logic       iord;        // 1 = data address from aluout
		logic       mem_write;
		logic       ir_write;
		logic       reg_write;
		logic       mem_to_reg;
		logic       zero_ext;    // andi / ori
		logic [1:0] reg_dst;
		logic [1:0] alu_src_a;
		logic [1:0] alu_src_b;
		logic [1:0] pc_src;
		logic [1:0] branch;      // bit0 beq, bit1 bne
		alu_op_e    alu_op;
		state_e     state;
	} ctrl_t;

endpackage

// File: hdl/mips_alu.sv
module mips_alu (
	input  logic [31:0]       a,
	input  logic [31:0]       b,
	input  mips_pkg::alu_op_e op,
	output logic [31:0]       result,
	output logic              zero
);
	import mips_pkg::*;

	logic [4:0] shamt;
	logic       less;

	assign shamt = a[4:0];                      // shift count from port a
	assign less  = $signed(a) < $signed(b);

	always_comb begin
		case (op)
			alu_add: result = a + b;
			alu_sub: result = a - b;
			alu_and: result = a & b;
			alu_or:  result = a | b;
			alu_slt: result = {31'b0, less};
			alu_sll: result = b << shamt;
			alu_srl: result = b >> shamt;       // logical, zero fill
			default: result = a + b;
		endcase
	end

	assign zero = (result == 32'b0);            // beq / bne test

endmodule

// File: hdl/mips_regfile.sv
module mips_regfile (
	input  logic        clk,
	input  logic        rstb,
	input  logic [4:0]  raddr_a,
	input  logic [4:0]  raddr_b,
	input  logic [4:0]  waddr,
	input  logic [31:0] wdata,
	input  logic        we,
	output logic [31:0] rdata_a,
	output logic [31:0] rdata_b
);

	logic [31:0] regs [32];

	always_ff @(posedge clk) begin
		if (!rstb) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= 32'b0;
		end else if (we && (waddr != 5'd0)) begin
			regs[waddr] <= wdata;               // r0 never written
		end
	end

	// async reads, r0 hardwired
	assign rdata_a = (raddr_a == 5'd0) ? 32'b0 : regs[raddr_a];
	assign rdata_b = (raddr_b == 5'd0) ? 32'b0 : regs[raddr_b];

endmodule

// File: hdl/mips_control.sv
module mips_control (
	input  logic             clk,
	input  logic             rstb,
	input  mips_pkg::instr_t instr,
	output mips_pkg::ctrl_t  ctrl
);
	import mips_pkg::*;

	state_e     state;
	state_e     state_nxt;
	logic [5:0] opcode;
	logic [5:0] funct;
	alu_op_e    funct_op;   // r-type operation from funct
	logic       funct_ok;
	logic       is_shift;   // sll / srl take shamt on port a

	assign opcode   = instr.r.opcode;
	assign funct    = instr.r.funct;
	assign is_shift = (funct == fn_sll) || (funct == fn_srl);

	always_comb begin
		funct_ok = 1'b1;
		funct_op = alu_add;
		case (funct)
			fn_add: funct_op = alu_add;
			fn_sub: funct_op = alu_sub;
			fn_and: funct_op = alu_and;
			fn_or:  funct_op = alu_or;
			fn_slt: funct_op = alu_slt;
			fn_sll: funct_op = alu_sll;
			fn_srl: funct_op = alu_srl;
			default: funct_ok = 1'b0;  // unsupported, dropped in decode
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstb)
			state <= st_fetch;
		else
			state <= state_nxt;
	end

	// next state
	always_comb begin
		case (state)
			st_fetch: state_nxt = st_decode;
			st_decode: begin
				case (opcode)
					op_lw, op_sw:            state_nxt = st_mem_addr;
					op_rtype:                state_nxt = funct_ok ? st_exec_r : st_fetch;
					op_addi, op_andi, op_ori: state_nxt = st_exec_i;
					op_beq, op_bne:          state_nxt = st_branch;
					op_j, op_jal:            state_nxt = st_jump;
					default:                 state_nxt = st_fetch;  // unknown op, no effect
				endcase
			end
			st_mem_addr: state_nxt = (opcode == op_lw) ? st_mem_read : st_mem_write;
			st_mem_read: state_nxt = st_mem_wb;
			st_exec_r:   state_nxt = st_alu_wb;
			st_exec_i:   state_nxt = st_alu_wb;
			default:     state_nxt = st_fetch;  // last cycle of every class
		endcase
	end

	// moore outputs, decoded from state and ir
	always_comb begin
		ctrl        = '0;
		ctrl.alu_op = alu_add;
		ctrl.state  = state;
		case (state)
			st_fetch: begin
				ctrl.ir_write  = 1'b1;
				ctrl.pc_write  = 1'b1;       // pc + 4
				ctrl.alu_src_a = srca_pc;
				ctrl.alu_src_b = srcb_four;
				ctrl.pc_src    = pcsrc_alu;
			end
			st_decode: begin
				// speculative branch target into aluout
				ctrl.alu_src_a = srca_pc;
				ctrl.alu_src_b = srcb_ext_sh2;
			end
			st_mem_addr: begin
				ctrl.alu_src_a = srca_a;     // base + offset
				ctrl.alu_src_b = srcb_ext;
			end
			st_mem_read: ctrl.iord = 1'b1;
			st_mem_wb: begin
				ctrl.reg_write  = 1'b1;
				ctrl.reg_dst    = dst_rt;
				ctrl.mem_to_reg = 1'b1;
			end
			st_mem_write: begin
				ctrl.iord      = 1'b1;
				ctrl.mem_write = 1'b1;
			end
			st_exec_r: begin
				ctrl.alu_src_a = is_shift ? srca_shamt : srca_a;
				ctrl.alu_src_b = srcb_b;
				ctrl.alu_op    = funct_op;
			end
			st_exec_i: begin
				ctrl.alu_src_a = srca_a;
				ctrl.alu_src_b = srcb_ext;
				ctrl.zero_ext  = (opcode != op_addi);  // logical imms
				case (opcode)
					op_andi: ctrl.alu_op = alu_and;
					op_ori:  ctrl.alu_op = alu_or;
					default: ctrl.alu_op = alu_add;
				endcase
			end
			st_alu_wb: begin
				ctrl.reg_write = 1'b1;
				ctrl.reg_dst   = (opcode == op_rtype) ? dst_rd : dst_rt;
			end
			st_branch: begin
				ctrl.alu_src_a = srca_a;     // compare by subtract
				ctrl.alu_src_b = srcb_b;
				ctrl.alu_op    = alu_sub;
				ctrl.pc_src    = pcsrc_aluout;
				ctrl.branch    = (opcode == op_bne) ? 2'b10 : 2'b01;
			end
			st_jump: begin
				ctrl.pc_write = 1'b1;
				ctrl.pc_src   = pcsrc_jump;
				if (opcode == op_jal) begin
					ctrl.reg_write = 1'b1;   // link, pc already +4
					ctrl.reg_dst   = dst_r31;
				end
			end
			default: ;
		endcase
	end

endmodule

// File: hdl/mips_core.sv
module mips_core (
	input  logic             clk,
	input  logic             rstb,
	input  mips_pkg::ctrl_t  ctrl,
	output mips_pkg::instr_t instr,
	output logic             zero,
	input  logic [31:0]      mem_rd_data,
	output logic [31:0]      mem_addr,
	output logic [31:0]      mem_wr_data,
	output logic             mem_wr_ena,
	output logic [31:0]      pc
);
	import mips_pkg::*;

	logic [31:0] mdr;
	logic [31:0] reg_a;
	logic [31:0] reg_b;
	logic [31:0] alu_out;
	logic [31:0] src_a;
	logic [31:0] src_b;
	logic [31:0] alu_result;
	logic [31:0] ext_imm;
	logic [31:0] rd_a;
	logic [31:0] rd_b;
	logic [31:0] wb_data;
	logic [4:0]  wb_addr;
	logic [31:0] pc_nxt;
	logic        pc_en;

	// sign or zero extend of the 16-bit immediate
	assign ext_imm = ctrl.zero_ext ? {16'b0, instr.i.imm} : {{16{instr.i.imm[15]}}, instr.i.imm};

	always_comb begin
		case (ctrl.alu_src_a)
			srca_a:     src_a = reg_a;
			srca_shamt: src_a = {27'b0, instr.r.shamt};
			default:    src_a = pc;
		endcase
		case (ctrl.alu_src_b)
			srcb_four:    src_b = 32'd4;
			srcb_ext:     src_b = ext_imm;
			srcb_ext_sh2: src_b = {ext_imm[29:0], 2'b00};  // word offset
			default:      src_b = reg_b;
		endcase
	end

	mips_alu u_alu (
		.a      (src_a),
		.b      (src_b),
		.op     (ctrl.alu_op),
		.result (alu_result),
		.zero   (zero)
	);

	// write-back target and source
	always_comb begin
		case (ctrl.reg_dst)
			dst_rd:  wb_addr = instr.r.rd;
			dst_r31: wb_addr = 5'd31;
			default: wb_addr = instr.r.rt;
		endcase
		if (ctrl.reg_dst == dst_r31)
			wb_data = pc;                       // return address
		else
			wb_data = ctrl.mem_to_reg ? mdr : alu_out;
	end

	mips_regfile u_regfile (
		.clk     (clk),
		.rstb    (rstb),
		.raddr_a (instr.r.rs),
		.raddr_b (instr.r.rt),
		.waddr   (wb_addr),
		.wdata   (wb_data),
		.we      (ctrl.reg_write),
		.rdata_a (rd_a),
		.rdata_b (rd_b)
	);

	// single port shared by fetch and data
	assign mem_addr    = ctrl.iord ? alu_out : pc;
	assign mem_wr_data = reg_b;
	assign mem_wr_ena  = ctrl.mem_write;

	// branch resolved here
	assign pc_en = ctrl.pc_write | (ctrl.branch[0] & zero) | (ctrl.branch[1] & ~zero);

	always_comb begin
		case (ctrl.pc_src)
			pcsrc_aluout: pc_nxt = alu_out;
			pcsrc_jump:   pc_nxt = {pc[31:28], instr.j.target, 2'b00};
			default:      pc_nxt = alu_result;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstb) begin
			pc      <= 32'b0;
			instr   <= '0;
			mdr     <= 32'b0;
			reg_a   <= 32'b0;
			reg_b   <= 32'b0;
			alu_out <= 32'b0;
		end else begin
			reg_a   <= rd_a;                    // a, b, aluout every cycle
			reg_b   <= rd_b;
			alu_out <= alu_result;
			if (ctrl.state == st_mem_read)
				mdr <= mem_rd_data;             // lw data only
			if (ctrl.ir_write)
				instr <= mem_rd_data;
			if (pc_en)
				pc <= pc_nxt;
		end
	end

endmodule

// File: hdl/mips_mem.sv
module mips_mem #(
	parameter int mem_words = 256
) (
	input  logic        clk,
	input  logic [31:0] addr,
	input  logic [31:0] wr_data,
	input  logic        wr_ena,
	output logic [31:0] rd_data,
	input  logic        load_en,
	input  logic [31:0] load_addr,
	input  logic [31:0] load_data
);

	localparam int aw = (mem_words > 1) ? $clog2(mem_words) : 1;
	localparam logic [29:0] depth = 30'(mem_words);

	logic [31:0]   mem [mem_words];
	logic [aw-1:0] core_idx;
	logic [aw-1:0] load_idx;

	// byte address in, word index out, wraps at depth
	assign core_idx = aw'(addr[31:2] % depth);
	assign load_idx = aw'(load_addr[31:2] % depth);

	assign rd_data = mem[core_idx];            // same-cycle read

	always_ff @(posedge clk) begin
		if (load_en)
			mem[load_idx] <= load_data;        // program load wins
		else if (wr_ena)
			mem[core_idx] <= wr_data;
	end

endmodule

// File: hdl/mips_system.sv
module mips_system #(
	parameter int mem_words = 256
) (
	input  logic        clk,
	input  logic        rstb,
	input  logic        load_en,
	input  logic [31:0] load_addr,
	input  logic [31:0] load_data,
	output logic [31:0] pc,
	output logic [31:0] mem_addr,
	output logic [31:0] mem_wr_data,
	output logic        mem_wr_ena
);
	import mips_pkg::*;

	ctrl_t       ctrl;
	instr_t      instr;        // ir back to the fsm
	logic [31:0] mem_rd_data;

	mips_control u_control (
		.clk   (clk),
		.rstb  (rstb),
		.instr (instr),
		.ctrl  (ctrl)
	);

	mips_core u_core (
		.clk         (clk),
		.rstb        (rstb),
		.ctrl        (ctrl),
		.instr       (instr),
		.zero        (),
		.mem_rd_data (mem_rd_data),
		.mem_addr    (mem_addr),
		.mem_wr_data (mem_wr_data),
		.mem_wr_ena  (mem_wr_ena),
		.pc          (pc)
	);

	mips_mem #(
		.mem_words (mem_words)
	) u_mem (
		.clk       (clk),
		.addr      (mem_addr),
		.wr_data   (mem_wr_data),
		.wr_ena    (mem_wr_ena),
		.rd_data   (mem_rd_data),
		.load_en   (load_en),
		.load_addr (load_addr),
		.load_data (load_data)
	);

endmodule

// File: verif/tb_programs.svh
`ifndef tb_programs_svh
`define tb_programs_svh

// r-type word, rd = rs op rt (shifts use rt and shamt)
function automatic logic [31:0] rtype_word(input logic [5:0] funct, input logic [4:0] rs,
		input logic [4:0] rt, input logic [4:0] rd, input logic [4:0] shamt);
	instr_t w;
	w.r.opcode = op_rtype;
	w.r.rs     = rs;
	w.r.rt     = rt;
	w.r.rd     = rd;
	w.r.shamt  = shamt;
	w.r.funct  = funct;
	return w;
endfunction

// i-type word, rt is the target for alu ops and lw, the source for sw
function automatic logic [31:0] itype_word(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
	instr_t w;
	w.i.opcode = op;
	w.i.rs     = rs;
	w.i.rt     = rt;
	w.i.imm    = imm;
	return w;
endfunction

// j / jal to a byte address in the same 256 MB region
function automatic logic [31:0] jtype_word(input logic [5:0] op, input logic [31:0] dest);
	instr_t w;
	w.j.opcode = op;
	w.j.target = dest[27:2];  // word index
	return w;
endfunction

`endif

// File: verif/tb_mips_system.sv
module tb_mips_system;
	timeunit 1ns;
	timeprecision 1ps;
	import mips_pkg::*;
	`include "tb_programs.svh"

	localparam int timeout_cycles = 300;  // cycles allowed per program

	logic        clk;
	logic        rstb;
	logic        load_en;
	logic [31:0] load_addr;
	logic [31:0] load_data;
	logic [31:0] pc;
	logic [31:0] mem_addr;
	logic [31:0] mem_wr_data;
	logic        mem_wr_ena;

	integer seed = 44514;
	int     errors = 0;
	int     tests = 0;
	int     next_pc_addr;          // where emit puts the next word

	logic [31:0] image_addr [$];   // words for the load port
	logic [31:0] image_data [$];
	logic [31:0] seen_addr [$];    // stores seen on the bus
	logic [31:0] seen_data [$];
	logic [31:0] exp_addr [$];
	logic [31:0] exp_data [$];

	mips_system #(
		.mem_words (256)
	) uut (
		.clk         (clk),
		.rstb        (rstb),
		.load_en     (load_en),
		.load_addr   (load_addr),
		.load_data   (load_data),
		.pc          (pc),
		.mem_addr    (mem_addr),
		.mem_wr_data (mem_wr_data),
		.mem_wr_ena  (mem_wr_ena)
	);

	initial clk = 1'b0;
	always #10 clk = ~clk;

	// sample mid-cycle before the write edge
	always @(negedge clk) begin
		if (rstb === 1'b1 && mem_wr_ena === 1'b1) begin
			seen_addr.push_back(mem_addr);
			seen_data.push_back(mem_wr_data);
		end
	end

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			errors++;
			$display("Error %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic clear_program();
		image_addr.delete();
		image_data.delete();
		exp_addr.delete();
		exp_data.delete();
		next_pc_addr = 0;
	endtask

	task automatic emit(input logic [31:0] word);
		image_addr.push_back(32'(next_pc_addr));
		image_data.push_back(word);
		next_pc_addr += 4;
	endtask

	task automatic preload(input logic [31:0] addr, input logic [31:0] data);
		image_addr.push_back(addr);   // data word outside the code
		image_data.push_back(data);
	endtask

	task automatic expect_store(input logic [31:0] addr, input logic [31:0] data);
		exp_addr.push_back(addr);
		exp_data.push_back(data);
	endtask

	// nop first so the last sw is done before pc reaches the spin
	task automatic halt_here(output logic [31:0] halt_addr);
		emit(itype_word(op_addi, 5'd0, 5'd0, 16'h0000));
		halt_addr = 32'(next_pc_addr);
		emit(jtype_word(op_j, halt_addr));   // jump to itself
	endtask

	task automatic compare_stores(input string name);
		int n;
		check_value({name, " store count"}, 32'(exp_addr.size()), 32'(seen_addr.size()));
		n = (seen_addr.size() < exp_addr.size()) ? seen_addr.size() : exp_addr.size();
		for (int k = 0; k < n; k++) begin
			check_value($sformatf("%s store %0d addr", name, k), exp_addr[k], seen_addr[k]);
			check_value($sformatf("%s store %0d data", name, k), exp_data[k], seen_data[k]);
		end
	endtask

	// load during reset then run until the halt loop
	task automatic run_program(input string name, input logic [31:0] halt_addr);
		int   i;
		int   cyc;
		logic done;
		tests++;
		@(posedge clk);
		#2;
		rstb    = 1'b0;
		load_en = 1'b0;
		@(posedge clk);                  // reset taken here
		#2;
		i   = 0;
		cyc = 1;
		while (i < image_addr.size() || cyc < 10) begin
			if (i < image_addr.size()) begin
				load_en   = 1'b1;
				load_addr = image_addr[i];
				load_data = image_data[i];
				i++;
			end else begin
				load_en = 1'b0;
			end
			@(negedge clk);
			check_value({name, " reset pc"}, 32'h0, pc);
			check_value({name, " reset mem_wr_ena"}, 32'h0, {31'b0, mem_wr_ena});
			@(posedge clk);
			#2;
			cyc++;
		end
		load_en = 1'b0;
		seen_addr.delete();
		seen_data.delete();
		rstb = 1'b1;
		@(negedge clk);                  // first cycle out of reset fetches from 0
		check_value({name, " first pc"}, 32'h0, pc);
		check_value({name, " first mem_addr"}, 32'h0, mem_addr);
		check_value({name, " first mem_wr_ena"}, 32'h0, {31'b0, mem_wr_ena});
		cyc  = 0;
		done = 1'b0;
		while (!done && cyc < timeout_cycles) begin
			@(negedge clk);
			cyc++;
			if (pc === halt_addr)
				done = 1'b1;
		end
		if (!done) begin
			errors++;
			$display("timeout in %s: pc never reached halt address %h, last pc %h",
				name, halt_addr, pc);
		end
		compare_stores(name);
	endtask

	task automatic reset_state_program();
		logic [31:0] halt;
		clear_program();
		halt_here(halt);                 // nop then spin without stores
		run_program("reset_state", halt);
	endtask

	task automatic arith_program();
		logic [15:0] imm1;
		logic [15:0] imm2;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] res [7];
		logic [31:0] halt;
		imm1 = 16'($random(seed));
		imm2 = 16'($random(seed));
		a = {{16{imm1[15]}}, imm1};       // addi sign extends
		b = {{16{imm2[15]}}, imm2};
		res[0] = a;
		res[1] = b;
		res[2] = a + b;
		res[3] = a - b;
		res[4] = a & b;
		res[5] = a | b;
		res[6] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
		clear_program();
		emit(itype_word(op_addi, 5'd0, 5'd1, imm1));
		emit(itype_word(op_addi, 5'd0, 5'd2, imm2));
		emit(rtype_word(fn_add, 5'd1, 5'd2, 5'd3, 5'd0));
		emit(rtype_word(fn_sub, 5'd1, 5'd2, 5'd4, 5'd0));
		emit(rtype_word(fn_and, 5'd1, 5'd2, 5'd5, 5'd0));
		emit(rtype_word(fn_or, 5'd1, 5'd2, 5'd6, 5'd0));
		emit(rtype_word(fn_slt, 5'd1, 5'd2, 5'd7, 5'd0));
		for (int k = 0; k < 7; k++) begin
			emit(itype_word(op_sw, 5'd0, 5'(k + 1), 16'(16'h0200 + 4 * k)));  // r1..r7
			expect_store(32'(32'h200 + 4 * k), res[k]);
		end
		halt_here(halt);
		run_program("arith", halt);
	endtask

	task automatic shift_zext_program();
		logic [15:0] imm3;
		logic [15:0] imm4;
		logic [4:0]  sh1;
		logic [4:0]  sh2;
		logic [31:0] z3;
		logic [31:0] z4;
		logic [31:0] halt;
		imm3 = 16'($random(seed)) | 16'h8000;   // bit 15 set to expose sign spread
		imm4 = 16'($random(seed)) | 16'h8000;
		sh1  = 5'($random(seed));
		sh2  = 5'($random(seed)) | 5'd1;        // nonzero so the zero fill shows
		z3 = {16'h0000, imm3};
		z4 = {16'h0000, imm4};
		clear_program();
		emit(itype_word(op_ori, 5'd0, 5'd1, imm3));
		emit(itype_word(op_addi, 5'd0, 5'd2, 16'hffff));     // r2 all ones
		emit(itype_word(op_andi, 5'd2, 5'd3, imm4));
		emit(rtype_word(fn_sll, 5'd0, 5'd1, 5'd4, sh1));
		emit(rtype_word(fn_srl, 5'd0, 5'd2, 5'd5, sh2));
		emit(itype_word(op_sw, 5'd0, 5'd1, 16'h0240));
		emit(itype_word(op_sw, 5'd0, 5'd3, 16'h0244));
		emit(itype_word(op_sw, 5'd0, 5'd4, 16'h0248));
		emit(itype_word(op_sw, 5'd0, 5'd5, 16'h024c));
		expect_store(32'h240, z3);
		expect_store(32'h244, 32'hffff_ffff & z4);
		expect_store(32'h248, z3 << sh1);
		expect_store(32'h24c, 32'hffff_ffff >> sh2);
		halt_here(halt);
		run_program("shift_zext", halt);
	endtask

	task automatic load_store_program();
		logic [31:0] d;
		logic [31:0] halt;
		d = 32'($random(seed));
		clear_program();
		emit(itype_word(op_lw, 5'd0, 5'd1, 16'h0300));
		emit(itype_word(op_addi, 5'd1, 5'd2, 16'h0123));
		emit(itype_word(op_sw, 5'd0, 5'd2, 16'h0304));
		halt_here(halt);
		preload(32'h300, d);
		expect_store(32'h304, d + 32'h123);
		run_program("load_store", halt);
	endtask

	// each taken branch skips one sw
	task automatic branch_program();
		logic [31:0] halt;
		clear_program();
		emit(itype_word(op_addi, 5'd0, 5'd1, 16'd5));
		emit(itype_word(op_addi, 5'd0, 5'd2, 16'd5));
		emit(itype_word(op_addi, 5'd0, 5'd3, 16'd7));
		emit(itype_word(op_beq, 5'd1, 5'd2, 16'd1));    // taken
		emit(itype_word(op_sw, 5'd0, 5'd3, 16'h0380));  // wrong path
		emit(itype_word(op_sw, 5'd0, 5'd3, 16'h0384));
		emit(itype_word(op_beq, 5'd1, 5'd3, 16'd1));    // not taken
		emit(itype_word(op_sw, 5'd0, 5'd1, 16'h0388));
		emit(itype_word(op_bne, 5'd1, 5'd3, 16'd1));    // taken
		emit(itype_word(op_sw, 5'd0, 5'd3, 16'h038c));  // wrong path
		emit(itype_word(op_sw, 5'd0, 5'd2, 16'h0390));
		emit(itype_word(op_bne, 5'd1, 5'd2, 16'd1));    // not taken
		emit(itype_word(op_sw, 5'd0, 5'd1, 16'h0394));
		halt_here(halt);
		expect_store(32'h384, 32'd7);
		expect_store(32'h388, 32'd5);
		expect_store(32'h390, 32'd5);
		expect_store(32'h394, 32'd5);
		run_program("branches", halt);
	endtask

	task automatic jump_link_program();
		logic [31:0] halt;
		clear_program();
		emit(itype_word(op_addi, 5'd0, 5'd1, 16'h0055));  // 0x00
		emit(jtype_word(op_j, 32'h0c));                   // 0x04 jumps over the sw
		emit(itype_word(op_sw, 5'd0, 5'd1, 16'h03a0));    // 0x08 never runs
		emit(jtype_word(op_jal, 32'h14));                 // 0x0c
		emit(itype_word(op_sw, 5'd0, 5'd1, 16'h03a4));    // 0x10 skipped since nothing returns
		emit(itype_word(op_sw, 5'd0, 5'd31, 16'h03a8));   // 0x14 subroutine entry
		halt_here(halt);
		expect_store(32'h3a8, 32'h0c + 32'd4);            // jal address plus four
		run_program("jump_link", halt);
	endtask

	initial begin
		rstb      = 1'b0;
		load_en   = 1'b0;
		load_addr = 32'h0;
		load_data = 32'h0;
		reset_state_program();
		arith_program();
		shift_zext_program();
		load_store_program();
		branch_program();
		jump_link_program();
		$display("tests run %0d, errors %0d", tests, errors);
		if (errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

// File: sim.f
hdl/mips_pkg.sv
hdl/mips_alu.sv
hdl/mips_regfile.sv
hdl/mips_control.sv
hdl/mips_core.sv
hdl/mips_mem.sv
hdl/mips_system.sv
+incdir+verif
verif/tb_mips_system.sv
